// ==== Makefile ====
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := PASS: all tests

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/icache_mem_model.sv ====
`timescale 1ns/1ps
/*
 * refill memory model
 * answers line requests from the cache after a random delay of 1 to 8
 * cycles. every word holds its own byte address xor a fixed pattern
 */
module icache_mem_model import icache_pkg::*; #(
  parameter word_t Pattern = 32'h0,
  parameter int    Seed    = 43
) (
  input  logic        clk_i,
  input  refill_req_t refill_req_i,
  output refill_rsp_t refill_rsp_o
);

  localparam int unsigned MAX_DELAY   = 8;
  localparam int unsigned DRIVE_DELAY = 5;

  integer      seed;
  int unsigned delay;

  // whole line, word i sits at line_addr + 4*i
  function automatic line_t line_at(input logic [ADDR_WIDTH-1:0] line_addr);
    line_t line;
    for (int i = 0; i < LINE_WORDS; i++) begin
      line[i] = (line_addr + ADDR_WIDTH'(4 * i)) ^ Pattern;
    end
    return line;
  endfunction

  ////////////////////////////////////////
  // four-phase responder
  ////////////////////////////////////////

  initial begin
    seed         = Seed;
    refill_rsp_o = '0;
    forever begin
      @(posedge clk_i);
      if (refill_req_i.req && !refill_rsp_o.ack) begin
        // 1 to 8 cycles until the line shows up
        delay = 1 + ($unsigned($random(seed)) % MAX_DELAY);
        repeat (delay) @(posedge clk_i);
        #DRIVE_DELAY;
        refill_rsp_o.line = line_at(refill_req_i.addr);
        refill_rsp_o.ack  = 1'b1;
        // line held until the cache lets go of req
        do @(posedge clk_i); while (refill_req_i.req);
        #DRIVE_DELAY;
        refill_rsp_o.ack  = 1'b0;
        refill_rsp_o.line = '0;
      end
    end
  end

endmodule

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
/*
 * instruction cache testbench
 * drives fetches into the cache over the four-phase port, the memory
 * model serves refills. concurrent assertions check words, refill and
 * miss activity, hit latency, flush length and the reset state
 */
module icache_tb import icache_pkg::*; ();

  localparam int          CLK_PERIOD  = 40;
  localparam int          DRIVE_DELAY = 5;
  localparam int          RESET_CYCLES = 16;
  localparam int          RAND_SEED   = 43;
  localparam word_t       MEM_PATTERN = 32'hC3A5_5A3C;
  // a hit sees req high on three edges before ack is sampled
  localparam int unsigned HIT_REQ_EDGES = 3;
  // fetches of all six tests together
  localparam int          NUM_FETCHES = 29;
  // worst case is a flush in front plus the longest refill delay plus handshake edges
  localparam int          FETCH_MAX_CYCLES = NUM_SETS + 8 + 24;
  localparam int          TIMEOUT_NS =
    (RESET_CYCLES + NUM_FETCHES * FETCH_MAX_CYCLES) * CLK_PERIOD;
  localparam logic [ADDR_WIDTH-1:0] ADDR_A  = 32'h0000_1230;
  localparam logic [ADDR_WIDTH-1:0] ADDR_IO = 32'h8000_0040;
  localparam int          CONFLICT_SET  = 5;
  localparam int          CONFLICT_TAG0 = 16;

  typedef enum logic [1:0] {EXP_HIT, EXP_MISS, EXP_NC, EXP_ANY} expect_e;

  logic        clk_i;
  logic        rst_ni;
  logic        en;
  logic        flush;
  logic        miss;
  logic        busy;
  fetch_req_t  fetch_req;
  fetch_rsp_t  fetch_rsp;
  refill_req_t refill_req;
  refill_rsp_t refill_rsp;
  // expectation of the running fetch
  expect_e     exp_kind;
  string       test_name;
  // per fetch monitors that are cleared while req is low
  logic        saw_refill;
  logic        saw_miss;
  int unsigned wait_cnt;
  int unsigned busy_len;

  icache_top #(
    .LfsrSeed ( 8'h5C )
  ) icache_top_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .en_i         ( en         ),
    .flush_i      ( flush      ),
    .fetch_req_i  ( fetch_req  ),
    .fetch_rsp_o  ( fetch_rsp  ),
    .refill_req_o ( refill_req ),
    .refill_rsp_i ( refill_rsp ),
    .miss_o       ( miss       ),
    .busy_o       ( busy       )
  );

  icache_mem_model #(
    .Pattern ( MEM_PATTERN ),
    .Seed    ( RAND_SEED   )
  ) mem_model_inst (
    .clk_i        ( clk_i      ),
    .refill_req_i ( refill_req ),
    .refill_rsp_o ( refill_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // reference rules and error reporting
  ////////////////////////////////////////

  // memory word = its byte address xor the pattern
  function automatic word_t expected_word(input logic [ADDR_WIDTH-1:0] byte_addr);
    return {byte_addr[ADDR_WIDTH-1:2], 2'b00} ^ MEM_PATTERN;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] line_base(input logic [ADDR_WIDTH-1:0] a);
    return {a[ADDR_WIDTH-1:LINE_OFS_WIDTH], LINE_OFS_WIDTH'(0)};
  endfunction

  // n-th line of one set with its own tag
  function automatic logic [ADDR_WIDTH-1:0] conflict_addr(input int n, input int ofs);
    return ADDR_WIDTH'(((CONFLICT_TAG0 + n) << (SET_IDX_WIDTH + LINE_OFS_WIDTH)) |
                       (CONFLICT_SET << LINE_OFS_WIDTH) | (ofs << BYTE_OFS_WIDTH));
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    abort_run();
  endtask

  task automatic report_fault(input string what);
    $display("test %s: %s", test_name, what);
    abort_run();
  endtask

  ////////////////////////////////////////
  // monitors and checks
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni || !busy) begin
      busy_len <= 0;
    end else begin
      busy_len <= busy_len + 1;
    end
    if (!fetch_req.req) begin
      saw_refill <= 1'b0;
      saw_miss   <= 1'b0;
      wait_cnt   <= 0;
    end else begin
      if (refill_req.req) saw_refill <= 1'b1;
      if (miss) saw_miss <= 1'b1;
      if (!fetch_rsp.ack) wait_cnt <= wait_cnt + 1;
    end
  end

  word_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp.ack |-> fetch_rsp.data == expected_word(fetch_req.addr.raw))
    else report_value("fetch word", expected_word(fetch_req.addr.raw), fetch_rsp.data);

  refill_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req.req |-> refill_req.addr == line_base(fetch_req.addr.raw))
    else report_value("refill address", line_base(fetch_req.addr.raw), refill_req.addr);

  refill_nc_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_req.req |-> refill_req.nc == (exp_kind == EXP_NC))
    else report_value("refill nc flag", 32'(exp_kind == EXP_NC), 32'(refill_req.nc));

  hit_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_rsp.ack) && exp_kind == EXP_HIT |-> !saw_refill && !saw_miss)
    else report_fault("expected hit went to memory or pulsed miss");

  hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_rsp.ack) && exp_kind == EXP_HIT |-> wait_cnt == HIT_REQ_EDGES)
    else report_value("hit latency in cycles", 32'(HIT_REQ_EDGES - 1), 32'(wait_cnt - 1));

  miss_seen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_rsp.ack) && exp_kind == EXP_MISS |-> saw_refill && saw_miss)
    else report_fault("expected miss without refill or miss pulse");

  nc_seen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_rsp.ack) && exp_kind == EXP_NC |-> saw_refill && !saw_miss)
    else report_fault("nc fetch skipped memory or pulsed miss");

  // a cacheable refill always counts as a miss
  refill_counted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(fetch_rsp.ack) && exp_kind == EXP_ANY |-> saw_refill == saw_miss)
    else report_fault("refill and miss pulse disagree");

  // one count per miss
  miss_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss |=> !miss)
    else report_fault("miss pulse longer than one cycle");

  ack_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_req.req && fetch_rsp.ack |=> fetch_rsp.ack)
    else report_fault("ack dropped while req still high");

  ack_released: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_req.req && fetch_rsp.ack |=> !fetch_rsp.ack)
    else report_fault("ack still high a cycle after req dropped");

  flush_length: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy) |-> busy_len == NUM_SETS)
    else report_value("flush cycles", NUM_SETS, $sampled(busy_len));

  reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !fetch_rsp.ack && !refill_req.req && !miss && busy)
    else report_fault("outputs not idle or no flush after reset");

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // one full four-phase fetch
  task automatic fetch(input logic [ADDR_WIDTH-1:0] addr, input expect_e kind);
    @(posedge clk_i);
    #DRIVE_DELAY;
    exp_kind           = kind;
    fetch_req.addr.raw = addr;
    fetch_req.req      = 1'b1;
    do @(posedge clk_i); while (!fetch_rsp.ack);
    #DRIVE_DELAY;
    fetch_req.req = 1'b0;
    do @(posedge clk_i); while (fetch_rsp.ack);
  endtask

  initial begin
    rst_ni    = 1'b0;
    en        = 1'b1;
    flush     = 1'b0;
    fetch_req = '0;
    exp_kind  = EXP_ANY;
    test_name = "reset";
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;

    // first fetch waits behind the reset flush
    test_name = "cold_miss";
    fetch(ADDR_A + 8, EXP_MISS);

    test_name = "hit";
    fetch(ADDR_A + 4, EXP_HIT);
    fetch(ADDR_A + 12, EXP_HIT);

    test_name = "nc_region";
    fetch(ADDR_IO, EXP_NC);
    fetch(ADDR_IO + 4, EXP_NC);
    fetch(ADDR_IO, EXP_NC);

    test_name = "disabled";
    @(posedge clk_i);
    #DRIVE_DELAY;
    en = 1'b0;
    fetch(ADDR_A, EXP_NC);
    fetch(ADDR_IO + 8, EXP_NC);
    @(posedge clk_i);
    #DRIVE_DELAY;
    en = 1'b1;
    wait (busy);
    wait (!busy);
    fetch(ADDR_A, EXP_MISS);

    test_name = "flush";
    fetch(ADDR_A + 4, EXP_HIT);
    @(posedge clk_i);
    #DRIVE_DELAY;
    flush = 1'b1;
    @(posedge clk_i);
    #DRIVE_DELAY;
    flush = 1'b0;
    // request raised while the sweep runs
    fetch(ADDR_A + 4, EXP_MISS);

    // six lines into one four-way set
    test_name = "replacement";
    for (int n = 0; n < NUM_WAYS + 2; n++) begin
      fetch(conflict_addr(n, n % LINE_WORDS), EXP_MISS);
    end
    for (int pass = 0; pass < 2; pass++) begin
      for (int n = 0; n < NUM_WAYS + 2; n++) begin
        fetch(conflict_addr(n, (n + pass + 1) % LINE_WORDS), EXP_ANY);
      end
    end

    $display("PASS: all tests");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    report_fault("watchdog expired, a handshake never completed");
  end

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
/*
 * icache control
 * main FSM of the cache. runs the fetch and refill handshakes, decides
 * non-cacheable fetches, keeps the enable, sweeps flushes and pulses
 * the miss counter
 */
module icache_ctrl import icache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  logic                flush_i,
  input  fetch_req_t          fetch_req_i,
  output fetch_rsp_t          fetch_rsp_o,
  output refill_req_t         refill_req_o,
  input  refill_rsp_t         refill_rsp_i,
  input  logic [NUM_WAYS-1:0] hit_i,
  input  logic                flush_done_i,
  input  word_t               word_i,
  output lookup_t             lookup_o,
  output logic                use_fill_o,
  output logic                alloc_o,
  output logic                miss_o,
  output logic                busy_o
);

  typedef enum logic [2:0] {
    FLUSH, IDLE, LOOKUP, COMPARE, REFILL, REFILL_RELEASE, RESPOND
  } state_e;

  state_e      state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  logic        nc_d, nc_q;
  logic        ack_d, ack_q;
  fetch_addr_u addr_d, addr_q;
  word_t       data_d, data_q;
  logic        cacheable_miss;

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // only cacheable misses allocate and count
  assign cacheable_miss = (state_q == COMPARE) & ~nc_q & ~(|hit_i);
  assign alloc_o        = cacheable_miss;
  assign miss_o         = cacheable_miss;
  assign busy_o         = (state_q == FLUSH);
  assign use_fill_o     = (state_q == REFILL);

  assign fetch_rsp_o.ack  = ack_q;
  assign fetch_rsp_o.data = data_q;

  // whole line is requested even for nc
  assign refill_req_o.req  = (state_q == REFILL);
  assign refill_req_o.nc   = nc_q;
  assign refill_req_o.addr = {addr_q.raw[ADDR_WIDTH-1:LINE_OFS_WIDTH], {LINE_OFS_WIDTH{1'b0}}};

  assign lookup_o.rd_en    = (state_q == LOOKUP);
  assign lookup_o.wr_en    = (state_q == REFILL) & refill_rsp_i.ack & ~nc_q;
  assign lookup_o.flush_en = (state_q == FLUSH);
  assign lookup_o.set_idx  = addr_q.fields.set_idx;
  assign lookup_o.tag      = addr_q.raw[ADDR_WIDTH-1 -: TAG_WIDTH];

  ////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    // disabling takes effect at once, enabling goes via flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    nc_d       = nc_q;
    addr_d     = addr_q;
    data_d     = data_q;
    // ack drops the cycle after req is seen low
    ack_d      = ack_q & fetch_req_i.req;

    unique case (state_q)
      FLUSH: begin
        if (flush_done_i) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (fetch_req_i.req && !ack_q) begin
          addr_d  = fetch_req_i.addr;
          nc_d    = fetch_req_i.addr.fields.io | ~cache_en_d;
          state_d = LOOKUP;
        end
      end
      // arrays read in this cycle
      LOOKUP: begin
        state_d = COMPARE;
      end
      COMPARE: begin
        if (!nc_q && (|hit_i)) begin
          ack_d   = 1'b1;
          data_d  = word_i;
          state_d = RESPOND;
        end else begin
          state_d = REFILL;
        end
      end
      // word taken straight from the refill line
      REFILL: begin
        if (refill_rsp_i.ack) begin
          ack_d   = 1'b1;
          data_d  = word_i;
          state_d = REFILL_RELEASE;
        end
      end
      REFILL_RELEASE: begin
        if (!refill_rsp_i.ack) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (!ack_q || !fetch_req_i.req) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= FLUSH;
      cache_en_q <= 1'b0;
      flush_q    <= 1'b0;
      nc_q       <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      nc_q       <= nc_d;
      ack_q      <= ack_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    data_q <= data_d;
  end

  legal_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, LOOKUP, COMPARE, REFILL, REFILL_RELEASE, RESPOND})
    else $error("icache ctrl: illegal FSM state");

  // four-phase refill, previous ack must be gone first
  refill_req_rise: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(refill_req_o.req) |-> !refill_rsp_i.ack)
    else $error("icache ctrl: refill req raised while ack still high");

endmodule

// ==== hdl/icache_data_store.sv ====
`timescale 1ns/1ps
/*
 * icache data store
 * one line array per way, written with the refill line into the victim
 * way and read for all ways in parallel; every way hands out the
 * addressed word of its line
 */
module icache_data_store import icache_pkg::*; (
  input  logic                       clk_i,
  input  lookup_t                    lookup_i,
  input  logic [NUM_WAYS-1:0]        victim_i,
  input  line_t                      fill_line_i,
  input  logic [WORD_OFS_WIDTH-1:0]  word_ofs_i,
  output word_t [NUM_WAYS-1:0]       way_words_o
);

  // line read per way, valid the cycle after rd_en
  line_t line_rd_q [NUM_WAYS];

  ////////////////////////////////////////
  // line arrays
  ////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    line_t line_mem [NUM_SETS];

    // refill goes to the victim way only
    always_ff @(posedge clk_i) begin
      if (lookup_i.wr_en && victim_i[w]) begin
        line_mem[lookup_i.set_idx] <= fill_line_i;
      end
    end

    // all ways are read, the tag compare picks one later
    always_ff @(posedge clk_i) begin
      if (lookup_i.rd_en) begin
        line_rd_q[w] <= line_mem[lookup_i.set_idx];
      end
    end

    // word select inside the line
    assign way_words_o[w] = line_rd_q[w][word_ofs_i];
  end

endmodule

// ==== hdl/icache_pkg.sv ====
/*
 * instruction cache package
 * cache geometry, the fetch address union and the bundles that travel
 * between the core, the cache, the refill memory and the internal stores
 */
package icache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  localparam int unsigned NUM_WAYS   = 4;
  localparam int unsigned NUM_SETS   = 16;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned ADDR_WIDTH = 32;

  // derived field widths
  localparam int unsigned WAY_IDX_WIDTH  = $clog2(NUM_WAYS);
  localparam int unsigned SET_IDX_WIDTH  = $clog2(NUM_SETS);
  localparam int unsigned WORD_OFS_WIDTH = $clog2(LINE_WORDS);
  localparam int unsigned BYTE_OFS_WIDTH = 2;
  localparam int unsigned LINE_OFS_WIDTH = WORD_OFS_WIDTH + BYTE_OFS_WIDTH;
  localparam int unsigned TAG_WIDTH      = ADDR_WIDTH - SET_IDX_WIDTH - LINE_OFS_WIDTH;

  typedef logic [31:0]            word_t;
  typedef word_t [LINE_WORDS-1:0] line_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;

  // one physical fetch address, read raw or split into fields
  // the top bit marks the non-cacheable io region
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    struct packed {
      logic                      io;
      logic [TAG_WIDTH-2:0]      tag_rest;
      logic [SET_IDX_WIDTH-1:0]  set_idx;
      logic [WORD_OFS_WIDTH-1:0] word_ofs;
      logic [BYTE_OFS_WIDTH-1:0] byte_ofs;
    } fields;
  } fetch_addr_u;

  ////////////////////////////////////////
  // port bundles
  ////////////////////////////////////////

  // core to cache
  typedef struct packed {
    logic        req;
    fetch_addr_u addr;
  } fetch_req_t;

  // cache to core
  typedef struct packed {
    logic  ack;
    word_t data;
  } fetch_rsp_t;

  // cache to memory, addr is always line aligned
  typedef struct packed {
    logic                  req;
    logic                  nc;
    logic [ADDR_WIDTH-1:0] addr;
  } refill_req_t;

  // memory to cache, line valid while ack is high
  typedef struct packed {
    logic  ack;
    line_t line;
  } refill_rsp_t;

  // command from the control to tag and data store
  typedef struct packed {
    logic                     rd_en;
    logic                     wr_en;
    logic                     flush_en;
    logic [SET_IDX_WIDTH-1:0] set_idx;
    tag_t                     tag;
  } lookup_t;

endpackage

// ==== hdl/icache_tag_store.sv ====
`timescale 1ns/1ps
/*
 * icache tag store
 * per-way tag arrays and valid bits, registered read and tag compare,
 * allocation into the victim way and the set-by-set flush sweep
 */
module icache_tag_store import icache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lookup_t             lookup_i,
  input  logic [NUM_WAYS-1:0] victim_i,
  output logic [NUM_WAYS-1:0] hit_o,
  output logic [NUM_WAYS-1:0] valid_o,
  output logic                flush_done_o
);

  // valid bits per way and set
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
  // set pointer of the flush sweep
  logic [SET_IDX_WIDTH-1:0]          flush_cnt_q;
  // read port registers
  tag_t                              tag_rd_q [NUM_WAYS];
  logic [NUM_WAYS-1:0]               valid_rd_q;
  tag_t                              cmp_tag_q;
  // way already holding the tag that is written
  logic [NUM_WAYS-1:0]               dup_tag;

  ////////////////////////////////////////
  // flush sweep
  ////////////////////////////////////////

  // last set of the sweep reached
  assign flush_done_o = lookup_i.flush_en & (flush_cnt_q == SET_IDX_WIDTH'(NUM_SETS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (flush_done_o) begin
      flush_cnt_q <= '0;
    end else if (lookup_i.flush_en) begin
      flush_cnt_q <= flush_cnt_q + 1'b1;
    end
  end

  // flush clears one set in all ways, a write sets the victim bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      valid_rd_q <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (lookup_i.flush_en) begin
          valid_q[w][flush_cnt_q] <= 1'b0;
        end else if (lookup_i.wr_en && victim_i[w]) begin
          valid_q[w][lookup_i.set_idx] <= 1'b1;
        end
        if (lookup_i.rd_en) begin
          valid_rd_q[w] <= valid_q[w][lookup_i.set_idx];
        end
      end
    end
  end

  // lookup tag kept next to the read data
  always_ff @(posedge clk_i) begin
    if (lookup_i.rd_en) begin
      cmp_tag_q <= lookup_i.tag;
    end
  end

  ////////////////////////////////////////
  // tag arrays and compare
  ////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    tag_t tag_mem [NUM_SETS];

    always_ff @(posedge clk_i) begin
      if (lookup_i.wr_en && victim_i[w]) begin
        tag_mem[lookup_i.set_idx] <= lookup_i.tag;
      end
      if (lookup_i.rd_en) begin
        tag_rd_q[w] <= tag_mem[lookup_i.set_idx];
      end
    end

    assign hit_o[w]   = valid_rd_q[w] & (tag_rd_q[w] == cmp_tag_q);
    assign dup_tag[w] = valid_q[w][lookup_i.set_idx] & (tag_mem[lookup_i.set_idx] == lookup_i.tag);
  end

  assign valid_o = valid_rd_q;

  // a read yields at most one matching way
  hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lookup_i.rd_en |=> $onehot0(hit_o))
    else $error("tag store: more than one way hits");

  // the control only allocates lines that missed
  no_dup_alloc: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lookup_i.wr_en |-> !(|dup_tag))
    else $error("tag store: line allocated twice in one set");

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
/*
 * instruction cache top level
 * four-way set-associative cache with a four-phase fetch port towards
 * the core and a four-phase line refill port towards memory
 */
module icache_top import icache_pkg::*; #(
  parameter logic [7:0] LfsrSeed = 8'hA5
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        en_i,
  input  logic        flush_i,
  input  fetch_req_t  fetch_req_i,
  output fetch_rsp_t  fetch_rsp_o,
  output refill_req_t refill_req_o,
  input  refill_rsp_t refill_rsp_i,
  output logic        miss_o,
  output logic        busy_o
);

  lookup_t              lookup;
  logic [NUM_WAYS-1:0]  hit;
  logic [NUM_WAYS-1:0]  valid;
  logic [NUM_WAYS-1:0]  victim;
  word_t [NUM_WAYS-1:0] way_words;
  word_t                word;
  logic                 flush_done;
  logic                 use_fill;
  logic                 alloc;

  icache_ctrl i_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .en_i         ( en_i         ),
    .flush_i      ( flush_i      ),
    .fetch_req_i  ( fetch_req_i  ),
    .fetch_rsp_o  ( fetch_rsp_o  ),
    .refill_req_o ( refill_req_o ),
    .refill_rsp_i ( refill_rsp_i ),
    .hit_i        ( hit          ),
    .flush_done_i ( flush_done   ),
    .word_i       ( word         ),
    .lookup_o     ( lookup       ),
    .use_fill_o   ( use_fill     ),
    .alloc_o      ( alloc        ),
    .miss_o       ( miss_o       ),
    .busy_o       ( busy_o       )
  );

  icache_tag_store i_tag_store (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .lookup_i     ( lookup     ),
    .victim_i     ( victim     ),
    .hit_o        ( hit        ),
    .valid_o      ( valid      ),
    .flush_done_o ( flush_done )
  );

  // core holds the address until ack, so the offset comes from the port
  icache_data_store i_data_store (
    .clk_i       ( clk_i                              ),
    .lookup_i    ( lookup                             ),
    .victim_i    ( victim                             ),
    .fill_line_i ( refill_rsp_i.line                  ),
    .word_ofs_i  ( fetch_req_i.addr.fields.word_ofs   ),
    .way_words_o ( way_words                          )
  );

  icache_way_select #(
    .LfsrSeed ( LfsrSeed )
  ) i_way_select (
    .clk_i       ( clk_i                            ),
    .rst_ni      ( rst_ni                           ),
    .hit_i       ( hit                              ),
    .valid_i     ( valid                            ),
    .way_words_i ( way_words                        ),
    .fill_line_i ( refill_rsp_i.line                ),
    .word_ofs_i  ( fetch_req_i.addr.fields.word_ofs ),
    .use_fill_i  ( use_fill                         ),
    .alloc_i     ( alloc                            ),
    .word_o      ( word                             ),
    .victim_o    ( victim                           )
  );

endmodule

// ==== hdl/icache_way_select.sv ====
`timescale 1ns/1ps
/*
 * icache way selector
 * picks the fetched word from the hitting way or from the refill line
 * and chooses the way to replace. an invalid way is taken first, with a
 * full set an 8-bit LFSR decides
 */
module icache_way_select import icache_pkg::*; #(
  parameter logic [7:0] LfsrSeed = 8'hA5
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [NUM_WAYS-1:0]       hit_i,
  input  logic [NUM_WAYS-1:0]       valid_i,
  input  word_t [NUM_WAYS-1:0]      way_words_i,
  input  line_t                     fill_line_i,
  input  logic [WORD_OFS_WIDTH-1:0] word_ofs_i,
  input  logic                      use_fill_i,
  input  logic                      alloc_i,
  output word_t                     word_o,
  output logic [NUM_WAYS-1:0]       victim_o
);

  logic [7:0]               lfsr_q;
  logic                     lfsr_fb;
  logic                     all_valid;
  logic [WAY_IDX_WIDTH-1:0] rnd_way;
  logic [NUM_WAYS-1:0]      first_inv;
  logic [NUM_WAYS-1:0]      rnd_oh;
  logic [NUM_WAYS-1:0]      victim_q;

  ////////////////////////////////////////
  // word select
  ////////////////////////////////////////

  always_comb begin
    word_o = '0;
    if (use_fill_i) begin
      word_o = fill_line_i[word_ofs_i];
    end else begin
      // hit vector is one-hot or zero
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (hit_i[w]) begin
          word_o = way_words_i[w];
        end
      end
    end
  end

  ////////////////////////////////////////
  // replacement
  ////////////////////////////////////////

  assign all_valid = &valid_i;
  assign rnd_way   = lfsr_q[WAY_IDX_WIDTH-1:0];
  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb   = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_comb begin
    first_inv = '0;
    rnd_oh    = '0;
    // lowest numbered free way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        first_inv    = '0;
        first_inv[w] = 1'b1;
      end
    end
    rnd_oh[rnd_way] = 1'b1;
  end

  // victim held from the compare cycle until the refill write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= NUM_WAYS'(1);
      lfsr_q   <= LfsrSeed;
    end else if (alloc_i) begin
      victim_q <= all_valid ? rnd_oh : first_inv;
      if (all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

  assign victim_o = victim_q;

  victim_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) alloc_i |=> $onehot(victim_o))
    else $error("way select: victim is not one-hot");

endmodule

// ==== vlog.f ====
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_way_select.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv
